// ==== filelist.f ====
usb_periph_pkg.sv
usb_detach_timer.sv
usb_mode_fsm.sv
usb_regs.sv
usb_serial_ep.sv
usb_periph_top.sv
usb_periph_checker.sv
tb_usb_periph.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_usb_periph
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
RUN_ARGS = +verilator+error+limit+1000

SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_usb_periph.sv ====
`timescale 1ns/1ns

module tb_usb_periph
   import usb_periph_pkg::*;
();

   logic        clk_i;
   logic        rst_i;
   cpu_req_t    cpu_req;
   usb_stream_t host_rx;
   logic        host_tx_ready;
   bus_data_t   rdata;
   logic        host_rx_ready;
   usb_stream_t host_tx;
   logic        dp_pull;

   int        err_cnt = 0;
   int        timeout_cnt = 0;
   int        tx_mode = 0; // 0 holds tx ready low and 1 throttles it at random
   integer    seed = 7;
   usb_byte_t tx_got[$];   // bytes seen leaving on host_tx

   usb_periph_top UUT (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cpu_req_i       (cpu_req),
      .host_rx_i       (host_rx),
      .host_tx_ready_i (host_tx_ready),
      .rdata_o         (rdata),
      .host_rx_ready_o (host_rx_ready),
      .host_tx_o       (host_tx),
      .usb_dp_pull_o   (dp_pull)
   );

   bind usb_periph_top usb_periph_checker u_checker (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .ccr_mode_i      (ccr_mode),
      .mode_wr_i       (mode_wr),
      .attached_i      (attached),
      .rx_full_i       (rx_full),
      .host_rx_i       (host_rx_i),
      .host_rx_ready_i (host_rx_ready_o),
      .host_tx_i       (host_tx_o),
      .host_tx_ready_i (host_tx_ready_i),
      .dp_pull_i       (usb_dp_pull_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // all stimulus and sampling happens 1 ns after the rising edge
   task automatic tick();
      @(posedge clk_i);
      #1;
   endtask

   task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         err_cnt++;
         $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic write_reg(input bus_addr_t addr, input bus_data_t data);
      cpu_req.write = 1'b1;
      cpu_req.be    = 4'hf;
      cpu_req.addr  = addr;
      cpu_req.wdata = data;
      tick(); // write lands on this edge
      cpu_req.write = 1'b0;
      cpu_req.wdata = '0;
   endtask

   task automatic read_reg(input bus_addr_t addr, output bus_data_t data);
      cpu_req.write = 1'b0;
      cpu_req.addr  = addr;
      tick();
      data = rdata;
   endtask

   // counts edges from the mode write until the pull-up is seen high
   task automatic wait_pull_high(input bit tx_idle, output int cycles);
      cycles = 0;
      while ((cycles == 0 || dp_pull !== 1'b1) && cycles < 100) begin
         tick();
         cycles++;
         if (tx_idle) begin
            expect_eq("host_tx_o.valid", 32'(host_tx.valid), 32'h0);
         end
      end
      if (dp_pull !== 1'b1) begin
         timeout_cnt++;
         $display("timeout: the pull-up never came back after the mode write");
      end
   endtask

   task automatic send_host_byte(input usb_byte_t b);
      int n;
      n = 0;
      host_rx.valid = 1'b1;
      host_rx.data  = b;
      while (host_rx_ready !== 1'b1 && n < 200) begin
         tick();
         n++;
      end
      if (host_rx_ready !== 1'b1) begin
         timeout_cnt++;
         $display("timeout: the host byte 0x%02h was never accepted", b);
      end
      tick(); // handshake edge
      host_rx.valid = 1'b0;
      host_rx.data  = '0;
   endtask

   task automatic wait_tx_count(input int k);
      int n;
      n = 0;
      while (tx_got.size() < k && n < 200) begin
         tick();
         n++;
      end
      if (tx_got.size() < k) begin
         timeout_cnt++;
         $display("timeout: only %0d of %0d bytes left on host tx", tx_got.size(), k);
      end
   endtask

   task automatic wait_rx_ready();
      int n;
      n = 0;
      while (host_rx_ready !== 1'b1 && n < 20) begin
         tick();
         n++;
      end
      if (host_rx_ready !== 1'b1) begin
         timeout_cnt++;
         $display("timeout: host rx ready did not return after clearing rx full");
      end
   endtask

   // host tx sink that logs a byte when valid and ready were both high at the last edge
   initial begin : host_tx_sink
      logic      ready_q;
      logic      valid_q;
      usb_byte_t data_q;
      integer    rnd;
      ready_q       = 1'b0;
      valid_q       = 1'b0;
      data_q        = '0;
      host_tx_ready = 1'b0;
      forever begin
         tick();
         if (ready_q && valid_q) begin
            tx_got.push_back(data_q);
         end
         if (tx_mode == 1) begin
            rnd           = $random(seed);
            host_tx_ready = rnd[0];
         end else begin
            host_tx_ready = 1'b0;
         end
         ready_q = host_tx_ready;
         valid_q = host_tx.valid;
         data_q  = host_tx.data;
      end
   end

   initial begin : main
      bus_data_t rd;
      int        cycles;
      usb_byte_t lb_bytes [4];
      cpu_req = '0;
      host_rx = '0;
      rst_i   = 1'b1;
      repeat (8) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      // reset state
      expect_eq("usb_dp_pull_o", 32'(dp_pull), 32'h0);
      expect_eq("host_rx_ready_o", 32'(host_rx_ready), 32'h0);
      expect_eq("host_tx_o.valid", 32'(host_tx.valid), 32'h0);
      expect_eq("rdata_o", rdata, 32'h0);
      read_reg(REG_CCR, rd);
      expect_eq("CCR", rd, 32'h0);
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h0);

      // attach timing and then a reserved code from the attached state
      write_reg(REG_CCR, bus_data_t'(MODE_SERIAL));
      wait_pull_high(1'b0, cycles);
      expect_eq("attach cycles", 32'(cycles), 32'(DETACH_CYCLES + 1));
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h4);
      write_reg(REG_CCR, 32'h5);
      tick();
      expect_eq("usb_dp_pull_o", 32'(dp_pull), 32'h0);
      repeat (2 * DETACH_CYCLES) begin
         tick();
         expect_eq("usb_dp_pull_o", 32'(dp_pull), 32'h0);
      end
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h0);
      read_reg(REG_CCR, rd);
      expect_eq("CCR", rd, 32'h5);
      write_reg(REG_CCR, bus_data_t'(MODE_SERIAL));
      wait_pull_high(1'b0, cycles);
      expect_eq("attach cycles", 32'(cycles), 32'(DETACH_CYCLES + 1));

      // transmit with tx ready held low first
      tx_got.delete();
      write_reg(REG_TDR, 32'ha5);
      tick();
      expect_eq("host_tx_o.valid", 32'(host_tx.valid), 32'h1);
      expect_eq("host_tx_o.data", 32'(host_tx.data), 32'ha5);
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h5);
      write_reg(REG_TDR, 32'h11); // ignored while busy
      repeat (4) begin
         tick();
         expect_eq("host_tx_o.valid", 32'(host_tx.valid), 32'h1);
         expect_eq("host_tx_o.data", 32'(host_tx.data), 32'ha5);
      end
      tx_mode = 1;
      wait_tx_count(1);
      repeat (10) tick();
      expect_eq("tx byte count", 32'(tx_got.size()), 32'h1);
      if (tx_got.size() > 0) begin
         expect_eq("host_tx_o.data", 32'(tx_got[0]), 32'ha5);
      end
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h4);

      // receive in serial mode
      send_host_byte(8'h3c);
      expect_eq("host_rx_ready_o", 32'(host_rx_ready), 32'h0);
      read_reg(REG_RDR, rd);
      expect_eq("RDR", rd, 32'h3c);
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h6);
      write_reg(REG_STA, 32'h2);
      wait_rx_ready();
      read_reg(REG_STA, rd);
      expect_eq("STA", rd, 32'h4);

      // loopback echoes in order and leaves RDR alone
      write_reg(REG_CCR, bus_data_t'(MODE_LOOPBACK));
      wait_pull_high(1'b0, cycles);
      expect_eq("attach cycles", 32'(cycles), 32'(DETACH_CYCLES + 1));
      tx_got.delete();
      for (int i = 0; i < 4; i++) begin
         lb_bytes[i] = usb_byte_t'(32'h5a + i * 37);
         send_host_byte(lb_bytes[i]);
      end
      wait_tx_count(4);
      expect_eq("loopback byte count", 32'(tx_got.size()), 32'h4);
      for (int i = 0; i < 4 && i < tx_got.size(); i++) begin
         expect_eq("host_tx_o.data", 32'(tx_got[i]), 32'(lb_bytes[i]));
      end
      read_reg(REG_RDR, rd);
      expect_eq("RDR", rd, 32'h3c);

      // mode change while attached drops a TDR write during settle
      tx_got.delete();
      write_reg(REG_CCR, bus_data_t'(MODE_SERIAL));
      tick();
      expect_eq("usb_dp_pull_o", 32'(dp_pull), 32'h0);
      expect_eq("host_rx_ready_o", 32'(host_rx_ready), 32'h0);
      write_reg(REG_TDR, 32'h77);
      wait_pull_high(1'b1, cycles);
      repeat (10) begin
         tick();
         expect_eq("host_tx_o.valid", 32'(host_tx.valid), 32'h0);
      end
      expect_eq("tx byte count", 32'(tx_got.size()), 32'h0);

      $display("checks done: %0d value errors, %0d timeouts, %0d assertion failures",
               err_cnt, timeout_cnt, UUT.u_checker.fail_cnt);
      if (err_cnt == 0 && timeout_cnt == 0 && UUT.u_checker.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== usb_periph_checker.sv ====
`timescale 1ns/1ns

module usb_periph_checker
   import usb_periph_pkg::*;
(
   input logic        clk_i,
   input logic        rst_i,
   input mode_t       ccr_mode_i,
   input logic        mode_wr_i,
   input logic        attached_i,
   input logic        rx_full_i,
   input usb_stream_t host_rx_i,
   input logic        host_rx_ready_i,
   input usb_stream_t host_tx_i,
   input logic        host_tx_ready_i,
   input logic        dp_pull_i
);

   int fail_cnt = 0; // read by the testbench at the end

   // a new personality takes the device off the bus on the next edge
   pull_drops: assert property (@(posedge clk_i) disable iff (rst_i)
      mode_wr_i |=> !dp_pull_i)
      else begin
         fail_cnt++;
         $error("pull-up still high one cycle after a mode change");
      end

   // re-attach only after the full settle period
   settle_len: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(dp_pull_i) |-> $past(mode_wr_i, DETACH_CYCLES + 1))
      else begin
         fail_cnt++;
         $error("pull-up rose without a mode write %0d cycles before", DETACH_CYCLES + 1);
      end

   rx_blocked_detached: assert property (@(posedge clk_i) disable iff (rst_i)
      !attached_i |-> !host_rx_ready_i)
      else begin
         fail_cnt++;
         $error("host rx ready high while detached");
      end

   // holding register is flushed one edge after detach
   tx_idle_detached: assert property (@(posedge clk_i) disable iff (rst_i)
      !attached_i |=> !host_tx_i.valid)
      else begin
         fail_cnt++;
         $error("host tx valid high while detached");
      end

   tx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      host_tx_i.valid && !host_tx_ready_i |=> host_tx_i.valid && $stable(host_tx_i.data))
      else begin
         fail_cnt++;
         $error("host tx byte dropped or changed before its handshake");
      end

   tx_release: assert property (@(posedge clk_i) disable iff (rst_i)
      host_tx_i.valid && host_tx_ready_i |=> !host_tx_i.valid)
      else begin
         fail_cnt++;
         $error("host tx valid stayed high after the handshake");
      end

   // source side hold rule for the host model
   rx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      host_rx_i.valid && !host_rx_ready_i |=> host_rx_i.valid && $stable(host_rx_i.data))
      else begin
         fail_cnt++;
         $error("host rx source changed its byte before the handshake");
      end

   rx_full_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
      host_rx_i.valid && host_rx_ready_i && ccr_mode_i == MODE_SERIAL
      |=> rx_full_i && !host_rx_ready_i)
      else begin
         fail_cnt++;
         $error("accepted serial byte did not set rx full and drop ready");
      end

endmodule

// ==== usb_periph_top.sv ====
`timescale 1ns/1ns

module usb_periph_top
   import usb_periph_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  cpu_req_t    cpu_req_i,
   input  usb_stream_t host_rx_i,
   input  logic        host_tx_ready_i,
   output bus_data_t   rdata_o,
   output logic        host_rx_ready_o,
   output usb_stream_t host_tx_o,
   output logic        usb_dp_pull_o
);

   mode_t     ccr_mode;
   logic      mode_wr;
   logic      tdr_wr;
   usb_byte_t tdr_byte;
   logic      rx_clr;
   usb_byte_t rx_byte;
   logic      rx_full;
   logic      tx_busy;
   logic      attached;
   logic      timer_start;
   logic      timer_done;

   // cpu side
   usb_regs u_regs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cpu_req_i  (cpu_req_i),
      .rx_byte_i  (rx_byte),
      .rx_full_i  (rx_full),
      .tx_busy_i  (tx_busy),
      .attached_i (attached),
      .rdata_o    (rdata_o),
      .ccr_mode_o (ccr_mode),
      .mode_wr_o  (mode_wr),
      .tdr_wr_o   (tdr_wr),
      .tdr_byte_o (tdr_byte),
      .rx_clr_o   (rx_clr)
   );

   // attach control and its settle timer
   usb_mode_fsm u_mode_fsm (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .mode_i        (ccr_mode),
      .mode_wr_i     (mode_wr),
      .timer_done_i  (timer_done),
      .timer_start_o (timer_start),
      .attached_o    (attached),
      .dp_pull_o     (usb_dp_pull_o)
   );

   usb_detach_timer u_detach_timer (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .start_i (timer_start),
      .done_o  (timer_done)
   );

   // host side data path
   usb_serial_ep u_serial_ep (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .mode_i          (ccr_mode),
      .attached_i      (attached),
      .host_rx_i       (host_rx_i),
      .host_tx_ready_i (host_tx_ready_i),
      .tdr_wr_i        (tdr_wr),
      .tdr_byte_i      (tdr_byte),
      .rx_clr_i        (rx_clr),
      .host_rx_ready_o (host_rx_ready_o),
      .host_tx_o       (host_tx_o),
      .rx_byte_o       (rx_byte),
      .rx_full_o       (rx_full),
      .tx_busy_o       (tx_busy)
   );

endmodule

// ==== usb_serial_ep.sv ====
`timescale 1ns/1ns

module usb_serial_ep
   import usb_periph_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  mode_t       mode_i,
   input  logic        attached_i,
   input  usb_stream_t host_rx_i,
   input  logic        host_tx_ready_i,
   input  logic        tdr_wr_i,
   input  usb_byte_t   tdr_byte_i,
   input  logic        rx_clr_i,
   output logic        host_rx_ready_o,
   output usb_stream_t host_tx_o,
   output usb_byte_t   rx_byte_o,
   output logic        rx_full_o,
   output logic        tx_busy_o
);

   logic      loopback;
   logic      serial;
   logic      rx_take;
   logic      tx_done;
   logic      tx_load;
   logic      rx_full_q;
   logic      tx_valid_q;
   usb_byte_t rx_data_q;
   usb_byte_t tx_data_q;

   assign loopback = attached_i & (mode_i == MODE_LOOPBACK);
   assign serial   = attached_i & (mode_i == MODE_SERIAL);

   // loopback waits for the tx holding register, serial for the cpu
   assign host_rx_ready_o = loopback ? ~tx_valid_q :
                            serial   ? ~rx_full_q  : 1'b0;

   assign rx_take = host_rx_i.valid & host_rx_ready_o;
   assign tx_done = tx_valid_q & host_tx_ready_i;
   assign tx_load = tdr_wr_i & serial & ~tx_valid_q; // dropped when busy or detached

   // holding flags
   always_ff @(posedge clk_i) begin
      if (rst_i || !attached_i) begin
         rx_full_q  <= 1'b0;
         tx_valid_q <= 1'b0;
      end else begin
         if (rx_take && !loopback) begin
            rx_full_q <= 1'b1;
         end else if (rx_clr_i) begin
            rx_full_q <= 1'b0;
         end
         if (tx_load || (rx_take && loopback)) begin
            tx_valid_q <= 1'b1;
         end else if (tx_done) begin
            tx_valid_q <= 1'b0;
         end
      end
   end

   // RDR is cpu visible so it starts from zero
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rx_data_q <= '0;
      end else if (rx_take && !loopback) begin
         rx_data_q <= host_rx_i.data;
      end
   end

   // tx payload, only sampled together with the valid flag
   always_ff @(posedge clk_i) begin
      if (rx_take && loopback) begin
         tx_data_q <= host_rx_i.data; // echo straight back
      end else if (tx_load) begin
         tx_data_q <= tdr_byte_i;
      end
   end

   assign host_tx_o.valid = tx_valid_q;
   assign host_tx_o.data  = tx_data_q;
   assign rx_byte_o       = rx_data_q;
   assign rx_full_o       = rx_full_q;
   assign tx_busy_o       = tx_valid_q;

endmodule

// ==== usb_regs.sv ====
`timescale 1ns/1ns

module usb_regs
   import usb_periph_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  cpu_req_t  cpu_req_i,
   input  usb_byte_t rx_byte_i,
   input  logic      rx_full_i,
   input  logic      tx_busy_i,
   input  logic      attached_i,
   output bus_data_t rdata_o,
   output mode_t     ccr_mode_o,
   output logic      mode_wr_o,
   output logic      tdr_wr_o,
   output usb_byte_t tdr_byte_o,
   output logic      rx_clr_o
);

   mode_t     ccr_q;
   mode_t     ccr_new;
   logic      lane0_wr;
   logic      ccr_sel;
   logic      tdr_sel;
   logic      sta_sel;
   bus_data_t sta_word;

   // CCR, TDR and STA only look at byte lane 0
   assign lane0_wr = cpu_req_i.write & cpu_req_i.be[0];
   assign ccr_sel  = lane0_wr & (cpu_req_i.addr == REG_CCR);
   assign tdr_sel  = lane0_wr & (cpu_req_i.addr == REG_TDR);
   assign sta_sel  = lane0_wr & (cpu_req_i.addr == REG_STA);

   assign ccr_new    = mode_t'(cpu_req_i.wdata[2:0]);
   assign ccr_mode_o = ccr_q;

   // status word as seen by the cpu
   always_comb begin
      sta_word               = '0;
      sta_word[STA_TX_BUSY]  = tx_busy_i;
      sta_word[STA_RX_FULL]  = rx_full_i;
      sta_word[STA_ATTACHED] = attached_i;
   end

   // control registers and the one-cycle strobes
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ccr_q     <= MODE_NONE;
         mode_wr_o <= 1'b0;
         tdr_wr_o  <= 1'b0;
         rx_clr_o  <= 1'b0;
      end else begin
         // a rewrite of the same code does not detach the device
         mode_wr_o <= ccr_sel & (ccr_new != ccr_q);
         tdr_wr_o  <= tdr_sel;
         rx_clr_o  <= sta_sel & cpu_req_i.wdata[STA_RX_FULL]; // write one to clear
         if (ccr_sel) begin
            ccr_q <= ccr_new;
         end
      end
   end

   // byte handed to the endpoint together with tdr_wr_o
   always_ff @(posedge clk_i) begin
      if (tdr_sel) begin
         tdr_byte_o <= cpu_req_i.wdata[7:0];
      end
   end

   // read data follows the address of the previous cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rdata_o <= '0;
      end else begin
         case (cpu_req_i.addr)
            REG_CCR: rdata_o <= bus_data_t'(ccr_q);
            REG_RDR: rdata_o <= bus_data_t'(rx_byte_i);
            REG_STA: rdata_o <= sta_word;
            default: rdata_o <= '0; // TDR is write only
         endcase
      end
   end

endmodule

// ==== usb_mode_fsm.sv ====
`timescale 1ns/1ns

module usb_mode_fsm
   import usb_periph_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_i,
   input  mode_t mode_i,
   input  logic  mode_wr_i,
   input  logic  timer_done_i,
   output logic  timer_start_o,
   output logic  attached_o,
   output logic  dp_pull_o
);

   attach_state_t state_q;
   attach_state_t state_d;
   logic          mode_ok;

   // only personalities that are actually built may attach
   assign mode_ok = (mode_i == MODE_SERIAL) | (mode_i == MODE_LOOPBACK);

   // a new personality always (re)starts the settle period
   assign timer_start_o = mode_wr_i & mode_ok;

   always_comb begin
      state_d = state_q;
      if (mode_wr_i) begin
         // any change of personality drops the device off the bus first
         state_d = mode_ok ? ST_SETTLE : ST_DETACHED;
      end else begin
         case (state_q)
            ST_DETACHED: state_d = ST_DETACHED; // wait for a valid mode write
            ST_SETTLE: begin
               if (timer_done_i) begin
                  state_d = ST_ATTACHED;
               end
            end
            ST_ATTACHED: state_d = ST_ATTACHED;
            default:     state_d = ST_DETACHED;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_DETACHED;
      end else begin
         state_q <= state_d;
      end
   end

   // pull-up follows the state register directly
   assign attached_o = (state_q == ST_ATTACHED);
   assign dp_pull_o  = (state_q == ST_ATTACHED);

endmodule

// ==== usb_detach_timer.sv ====
`timescale 1ns/1ns

module usb_detach_timer
   import usb_periph_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic start_i,
   output logic done_o
);

   localparam detach_cnt_t LOAD_VAL = detach_cnt_t'(DETACH_CYCLES - 1);

   detach_cnt_t cnt_q;
   logic        run_q;

   // count down from LOAD_VAL, done on the cycle the count sits at zero
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cnt_q <= '0;
         run_q <= 1'b0;
      end else if (start_i) begin
         cnt_q <= LOAD_VAL; // a restart simply reloads
         run_q <= 1'b1;
      end else if (run_q) begin
         if (cnt_q == '0) begin
            run_q <= 1'b0;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   assign done_o = run_q & (cnt_q == '0); // single cycle pulse

endmodule

// ==== usb_periph_pkg.sv ====
package usb_periph_pkg;

   // widths with a meaning on the bus and the host side
   typedef logic [31:0] bus_data_t;   // cpu register word
   typedef logic [3:0]  bus_addr_t;   // byte address inside the peripheral
   typedef logic [3:0]  byte_en_t;    // one bit per byte lane
   typedef logic [7:0]  usb_byte_t;   // payload byte
   typedef logic [2:0]  mode_t;       // device personality code
   typedef logic [4:0]  detach_cnt_t; // settle timer value

   // register offsets
   localparam bus_addr_t REG_CCR = 4'd0;
   localparam bus_addr_t REG_RDR = 4'd4;
   localparam bus_addr_t REG_TDR = 4'd8;
   localparam bus_addr_t REG_STA = 4'd12;

   // personality codes, 3 to 7 reserved
   localparam mode_t MODE_NONE     = 3'd0;
   localparam mode_t MODE_SERIAL   = 3'd1;
   localparam mode_t MODE_LOOPBACK = 3'd2;

   // bit positions in STA
   localparam int STA_TX_BUSY  = 0;
   localparam int STA_RX_FULL  = 1;
   localparam int STA_ATTACHED = 2;

   // detached settle time in clock cycles
   localparam int DETACH_CYCLES = 16;

   typedef enum logic [1:0] {
      ST_DETACHED,
      ST_SETTLE,
      ST_ATTACHED
   } attach_state_t;

   typedef struct packed {
      logic      valid;
      usb_byte_t data;
   } usb_stream_t;

   typedef struct packed {
      logic      write;
      byte_en_t  be;
      bus_addr_t addr;
      bus_data_t wdata;
   } cpu_req_t;

endpackage
